// File: Makefile
# Verilator build and run of the mini_mcu testbench
VERILATOR ?= verilator
TOP       ?= tb_mini_mcu
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= TEST PASS
VFLAGS    ?= --binary --assert -j 0 --timescale 1ns/10ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: list.f
src/mini_mcu_pkg.sv
src/uart_tx.sv
src/system_bus.sv
src/memory_subsystem.sv
src/peripheral_subsystem.sv
src/mini_mcu.sv
test/tb_mini_mcu.sv

// File: src/memory_subsystem.sv
////////////////////////////////////////
// two 256 word banks use addr bits 9:2 only
// reading a word before its first write returns X
////////////////////////////////////////
`timescale 1ns/10ps

module memory_subsystem (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                ram0_req_i, ram0_we_i,
  input  mini_mcu_pkg::addr_t ram0_addr_i,
  input  mini_mcu_pkg::be_t   ram0_be_i,
  input  mini_mcu_pkg::data_t ram0_wdata_i,
  output logic                ram0_gnt_o, ram0_rvalid_o,
  output mini_mcu_pkg::data_t ram0_rdata_o,
  input  logic                ram1_req_i, ram1_we_i,
  input  mini_mcu_pkg::addr_t ram1_addr_i,
  input  mini_mcu_pkg::be_t   ram1_be_i,
  input  mini_mcu_pkg::data_t ram1_wdata_i,
  output logic                ram1_gnt_o, ram1_rvalid_o,
  output mini_mcu_pkg::data_t ram1_rdata_o
);
  import mini_mcu_pkg::*;

  logic  req      [RAM_NUM_BANKS];
  logic  we       [RAM_NUM_BANKS];
  addr_t addr     [RAM_NUM_BANKS];
  be_t   be       [RAM_NUM_BANKS];
  data_t wdata    [RAM_NUM_BANKS];
  logic  rvalid_q [RAM_NUM_BANKS];
  data_t rdata_q  [RAM_NUM_BANKS];

  assign {req[0], we[0], addr[0], be[0], wdata[0]} =
    {ram0_req_i, ram0_we_i, ram0_addr_i, ram0_be_i, ram0_wdata_i};
  assign {req[1], we[1], addr[1], be[1], wdata[1]} =
    {ram1_req_i, ram1_we_i, ram1_addr_i, ram1_be_i, ram1_wdata_i};

  // banks never stall
  assign ram0_gnt_o    = ram0_req_i;
  assign ram1_gnt_o    = ram1_req_i;
  assign ram0_rvalid_o = rvalid_q[0];
  assign ram1_rvalid_o = rvalid_q[1];
  assign ram0_rdata_o  = rdata_q[0];
  assign ram1_rdata_o  = rdata_q[1];

  for (genvar b = 0; b < RAM_NUM_BANKS; b++) begin : g_bank
    data_t     mem_q [RAM_BANK_WORDS];
    word_idx_t idx;

    assign idx = addr[b][RAM_ADDR_LSB-1:2];

    always_ff @(posedge clk_i) begin
      if (req[b] && we[b]) begin
        for (int i = 0; i < 4; i++) begin
          if (be[b][i]) begin
            mem_q[idx][8*i +: 8] <= wdata[b][8*i +: 8];
          end
        end
      end
      if (req[b] && !we[b]) begin
        rdata_q[b] <= mem_q[idx];
      end
    end

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        rvalid_q[b] <= 1'b0;
      end else begin
        rvalid_q[b] <= req[b];
      end
    end
  end

endmodule

// File: src/mini_mcu.sv
////////////////////////////////////////
// host port stands in for the core data port
// no cpu, debug, irq or uart rx
////////////////////////////////////////
`timescale 1ns/10ps

module mini_mcu (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                host_req_i, host_we_i,
  input  mini_mcu_pkg::addr_t host_addr_i,
  input  mini_mcu_pkg::be_t   host_be_i,
  input  mini_mcu_pkg::data_t host_wdata_i,
  output logic                host_gnt_o, host_rvalid_o,
  output mini_mcu_pkg::data_t host_rdata_o,
  input  logic                ext_req_i, ext_we_i,
  input  mini_mcu_pkg::addr_t ext_addr_i,
  input  mini_mcu_pkg::be_t   ext_be_i,
  input  mini_mcu_pkg::data_t ext_wdata_i,
  output logic                ext_gnt_o, ext_rvalid_o,
  output mini_mcu_pkg::data_t ext_rdata_o,
  output logic                exit_valid_o,
  output mini_mcu_pkg::data_t exit_value_o,
  output logic                uart_tx_o
);
  import mini_mcu_pkg::*;

  logic  ram0_req, ram0_we, ram0_gnt, ram0_rvalid;
  addr_t ram0_addr;
  be_t   ram0_be;
  data_t ram0_wdata, ram0_rdata;
  logic  ram1_req, ram1_we, ram1_gnt, ram1_rvalid;
  addr_t ram1_addr;
  be_t   ram1_be;
  data_t ram1_wdata, ram1_rdata;
  logic  periph_req, periph_we, periph_gnt, periph_rvalid;
  addr_t periph_addr;
  be_t   periph_be;
  data_t periph_wdata, periph_rdata;

  // master ports and clock/reset match by name
  system_bus u_system_bus (
    .*,
    .ram0_req_o     (ram0_req),
    .ram0_addr_o    (ram0_addr),
    .ram0_we_o      (ram0_we),
    .ram0_be_o      (ram0_be),
    .ram0_wdata_o   (ram0_wdata),
    .ram0_gnt_i     (ram0_gnt),
    .ram0_rvalid_i  (ram0_rvalid),
    .ram0_rdata_i   (ram0_rdata),
    .ram1_req_o     (ram1_req),
    .ram1_addr_o    (ram1_addr),
    .ram1_we_o      (ram1_we),
    .ram1_be_o      (ram1_be),
    .ram1_wdata_o   (ram1_wdata),
    .ram1_gnt_i     (ram1_gnt),
    .ram1_rvalid_i  (ram1_rvalid),
    .ram1_rdata_i   (ram1_rdata),
    .periph_req_o   (periph_req),
    .periph_addr_o  (periph_addr),
    .periph_we_o    (periph_we),
    .periph_be_o    (periph_be),
    .periph_wdata_o (periph_wdata),
    .periph_gnt_i   (periph_gnt),
    .periph_rvalid_i(periph_rvalid),
    .periph_rdata_i (periph_rdata)
  );

  memory_subsystem u_memory_subsystem (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ram0_req_i   (ram0_req),
    .ram0_addr_i  (ram0_addr),
    .ram0_we_i    (ram0_we),
    .ram0_be_i    (ram0_be),
    .ram0_wdata_i (ram0_wdata),
    .ram0_gnt_o   (ram0_gnt),
    .ram0_rvalid_o(ram0_rvalid),
    .ram0_rdata_o (ram0_rdata),
    .ram1_req_i   (ram1_req),
    .ram1_addr_i  (ram1_addr),
    .ram1_we_i    (ram1_we),
    .ram1_be_i    (ram1_be),
    .ram1_wdata_i (ram1_wdata),
    .ram1_gnt_o   (ram1_gnt),
    .ram1_rvalid_o(ram1_rvalid),
    .ram1_rdata_o (ram1_rdata)
  );

  peripheral_subsystem u_peripheral_subsystem (
    .*,
    .periph_req_i   (periph_req),
    .periph_addr_i  (periph_addr),
    .periph_we_i    (periph_we),
    .periph_be_i    (periph_be),
    .periph_wdata_i (periph_wdata),
    .periph_gnt_o   (periph_gnt),
    .periph_rvalid_o(periph_rvalid),
    .periph_rdata_o (periph_rdata)
  );

endmodule

// File: src/mini_mcu_pkg.sv
////////////////////////////////////////
// bank size and peripheral window are fixed here
// register offsets are word aligned inside 4 KiB
////////////////////////////////////////
package mini_mcu_pkg;

  // bus widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;
  typedef logic [7:0]  word_idx_t;
  typedef logic [11:0] periph_off_t;

  // memory map
  localparam int unsigned RAM_NUM_BANKS   = 2;
  localparam int unsigned RAM_BANK_WORDS  = 256;
  localparam int unsigned RAM_ADDR_LSB    = $clog2(RAM_BANK_WORDS) + 2;
  localparam addr_t       RAM0_BASE       = 32'h0000_0000;
  localparam addr_t       RAM1_BASE       = 32'h0000_0400;
  localparam addr_t       PERIPH_BASE     = 32'h2000_0000;
  localparam int unsigned PERIPH_ADDR_LSB = 12;

  // peripheral registers
  localparam periph_off_t EXIT_OFFSET        = 12'h000;
  localparam periph_off_t UART_TX_OFFSET     = 12'h010;
  localparam periph_off_t UART_STATUS_OFFSET = 12'h014;

  // returned for unmapped reads
  localparam data_t BUS_ERR_RDATA = 32'hBADC_0DE0;

  // uart bit timing
  localparam int unsigned UART_CLKS_PER_BIT = 4;
  localparam int unsigned UART_CNT_W        = $clog2(UART_CLKS_PER_BIT);

  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } uart_state_t;

endpackage

// File: src/peripheral_subsystem.sv
////////////////////////////////////////
// exit, uart data and uart status registers
// a UART_TX write stalls while a frame is out
////////////////////////////////////////
`timescale 1ns/10ps

module peripheral_subsystem (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                periph_req_i,
  input  mini_mcu_pkg::addr_t periph_addr_i,
  input  logic                periph_we_i,
  input  mini_mcu_pkg::be_t   periph_be_i,
  input  mini_mcu_pkg::data_t periph_wdata_i,
  output logic                periph_gnt_o,
  output logic                periph_rvalid_o,
  output mini_mcu_pkg::data_t periph_rdata_o,
  output logic                exit_valid_o,
  output mini_mcu_pkg::data_t exit_value_o,
  output logic                uart_tx_o
);
  import mini_mcu_pkg::*;

  periph_off_t offset;
  logic        is_exit, is_tx, is_status;
  logic        tx_wr, gnt, uart_busy, uart_start;
  logic        rvalid_q, exit_valid_q;
  data_t       rdata_q, exit_value_q;

  assign offset    = periph_addr_i[PERIPH_ADDR_LSB-1:0];
  assign is_exit   = offset == EXIT_OFFSET;
  assign is_tx     = offset == UART_TX_OFFSET;
  assign is_status = offset == UART_STATUS_OFFSET;

  // only back-pressure in the system
  assign tx_wr      = periph_req_i & periph_we_i & is_tx;
  assign gnt        = periph_req_i & ~(tx_wr & uart_busy);
  assign uart_start = tx_wr & ~uart_busy;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q     <= 1'b0;
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else begin
      rvalid_q <= gnt;
      if (gnt && periph_we_i && is_exit) begin
        exit_valid_q <= 1'b1;
        for (int i = 0; i < 4; i++) begin
          if (periph_be_i[i]) begin
            exit_value_q[8*i +: 8] <= periph_wdata_i[8*i +: 8];
          end
        end
      end
    end
  end

  // read data, tx and unknown offsets read zero
  always_ff @(posedge clk_i) begin
    if (gnt && !periph_we_i) begin
      if (is_exit) begin
        rdata_q <= exit_value_q;
      end else if (is_status) begin
        rdata_q <= data_t'(uart_busy);
      end else begin
        rdata_q <= '0;
      end
    end
  end

  uart_tx u_uart_tx (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .start_i(uart_start),
    .data_i (periph_wdata_i[7:0]),
    .busy_o (uart_busy),
    .tx_o   (uart_tx_o)
  );

  assign periph_gnt_o    = gnt;
  assign periph_rvalid_o = rvalid_q;
  assign periph_rdata_o  = rdata_q;
  assign exit_valid_o    = exit_valid_q;
  assign exit_value_o    = exit_value_q;

endmodule

// File: src/system_bus.sv
////////////////////////////////////////
// at most one grant per cycle across two masters
// every target must answer one cycle after gnt
////////////////////////////////////////
`timescale 1ns/10ps

module system_bus (
  input  logic                clk_i,
  input  logic                rst_i,
  // host master
  input  logic                host_req_i, host_we_i,
  input  mini_mcu_pkg::addr_t host_addr_i,
  input  mini_mcu_pkg::be_t   host_be_i,
  input  mini_mcu_pkg::data_t host_wdata_i,
  output logic                host_gnt_o, host_rvalid_o,
  output mini_mcu_pkg::data_t host_rdata_o,
  // external master
  input  logic                ext_req_i, ext_we_i,
  input  mini_mcu_pkg::addr_t ext_addr_i,
  input  mini_mcu_pkg::be_t   ext_be_i,
  input  mini_mcu_pkg::data_t ext_wdata_i,
  output logic                ext_gnt_o, ext_rvalid_o,
  output mini_mcu_pkg::data_t ext_rdata_o,
  // ram bank 0
  output logic                ram0_req_o, ram0_we_o,
  output mini_mcu_pkg::addr_t ram0_addr_o,
  output mini_mcu_pkg::be_t   ram0_be_o,
  output mini_mcu_pkg::data_t ram0_wdata_o,
  input  logic                ram0_gnt_i, ram0_rvalid_i,
  input  mini_mcu_pkg::data_t ram0_rdata_i,
  // ram bank 1
  output logic                ram1_req_o, ram1_we_o,
  output mini_mcu_pkg::addr_t ram1_addr_o,
  output mini_mcu_pkg::be_t   ram1_be_o,
  output mini_mcu_pkg::data_t ram1_wdata_o,
  input  logic                ram1_gnt_i, ram1_rvalid_i,
  input  mini_mcu_pkg::data_t ram1_rdata_i,
  // peripheral block
  output logic                periph_req_o, periph_we_o,
  output mini_mcu_pkg::addr_t periph_addr_o,
  output mini_mcu_pkg::be_t   periph_be_o,
  output mini_mcu_pkg::data_t periph_wdata_o,
  input  logic                periph_gnt_i, periph_rvalid_i,
  input  mini_mcu_pkg::data_t periph_rdata_i
);
  import mini_mcu_pkg::*;

  logic       last_ext_q;
  logic       sel_ext, win_req, win_we;
  addr_t      win_addr;
  be_t        win_be;
  data_t      win_wdata;
  logic       hit_ram0, hit_ram1, hit_periph;
  logic [3:0] sel;
  logic [3:0] rsp_sel_q;
  logic       tgt_gnt, rsp_valid;
  data_t      rsp_rdata;

  // ext only wins a tie if host went last
  assign sel_ext   = ext_req_i & (~host_req_i | ~last_ext_q);
  assign win_req   = host_req_i | ext_req_i;
  assign win_addr  = sel_ext ? ext_addr_i : host_addr_i;
  assign win_we    = sel_ext ? ext_we_i : host_we_i;
  assign win_be    = sel_ext ? ext_be_i : host_be_i;
  assign win_wdata = sel_ext ? ext_wdata_i : host_wdata_i;

  assign hit_ram0   = win_addr[31:RAM_ADDR_LSB] == RAM0_BASE[31:RAM_ADDR_LSB];
  assign hit_ram1   = win_addr[31:RAM_ADDR_LSB] == RAM1_BASE[31:RAM_ADDR_LSB];
  assign hit_periph = win_addr[31:PERIPH_ADDR_LSB] == PERIPH_BASE[31:PERIPH_ADDR_LSB];

  // {err, periph, ram1, ram0}
  assign sel = {4{win_req}} & {~(hit_ram0 | hit_ram1 | hit_periph), hit_periph,
                               hit_ram1, hit_ram0};

  assign ram0_req_o   = sel[0];
  assign ram1_req_o   = sel[1];
  assign periph_req_o = sel[2];
  assign {ram0_addr_o, ram1_addr_o, periph_addr_o}    = {3{win_addr}};
  assign {ram0_we_o, ram1_we_o, periph_we_o}          = {3{win_we}};
  assign {ram0_be_o, ram1_be_o, periph_be_o}          = {3{win_be}};
  assign {ram0_wdata_o, ram1_wdata_o, periph_wdata_o} = {3{win_wdata}};

  // error responder always grants
  assign tgt_gnt    = |(sel & {1'b1, periph_gnt_i, ram1_gnt_i, ram0_gnt_i});
  assign host_gnt_o = tgt_gnt & ~sel_ext;
  assign ext_gnt_o  = tgt_gnt & sel_ext;

  // last_ext_q also names the owner of the response in flight
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_sel_q  <= '0;
      last_ext_q <= 1'b1;
    end else begin
      rsp_sel_q <= tgt_gnt ? sel : '0;
      if (tgt_gnt) begin
        last_ext_q <= sel_ext;
      end
    end
  end

  assign rsp_valid = (rsp_sel_q[0] & ram0_rvalid_i) | (rsp_sel_q[1] & ram1_rvalid_i) |
                     (rsp_sel_q[2] & periph_rvalid_i) | rsp_sel_q[3];
  assign rsp_rdata = ({32{rsp_sel_q[0]}} & ram0_rdata_i) |
                     ({32{rsp_sel_q[1]}} & ram1_rdata_i) |
                     ({32{rsp_sel_q[2]}} & periph_rdata_i) |
                     ({32{rsp_sel_q[3]}} & BUS_ERR_RDATA);

  assign host_rvalid_o = rsp_valid & ~last_ext_q;
  assign ext_rvalid_o  = rsp_valid & last_ext_q;
  assign host_rdata_o  = rsp_rdata;
  assign ext_rdata_o   = rsp_rdata;

  // address map regions must not overlap
  a_one_target: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(sel));
  // targets answer exactly one cycle later
  a_host_gnt_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
    host_gnt_o |=> host_rvalid_o);
  a_ext_gnt_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
    ext_gnt_o |=> ext_rvalid_o);

endmodule

// File: src/uart_tx.sv
////////////////////////////////////////
// 8N1 only, fixed bit period, no fifo
// start_i is ignored unless idle
////////////////////////////////////////
`timescale 1ns/10ps

module uart_tx (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       start_i,
  input  logic [7:0] data_i,
  output logic       busy_o,
  output logic       tx_o
);
  import mini_mcu_pkg::*;

  uart_state_t           state_q;
  logic [UART_CNT_W-1:0] cnt_q;
  logic [2:0]            bit_q;
  logic [7:0]            shift_q;
  logic                  bit_end;

  assign bit_end = cnt_q == UART_CNT_W'(UART_CLKS_PER_BIT - 1);
  assign busy_o  = state_q != IDLE;

  always_comb begin
    case (state_q)
      START:   tx_o = 1'b0;
      DATA:    tx_o = shift_q[0];
      default: tx_o = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      bit_q   <= '0;
    end else begin
      if (state_q == IDLE || bit_end) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
      case (state_q)
        IDLE: begin
          if (start_i) begin
            state_q <= START;
          end
        end
        START: begin
          if (bit_end) begin
            state_q <= DATA;
            bit_q   <= '0;
          end
        end
        DATA: begin
          if (bit_end) begin
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) begin
              state_q <= STOP;
            end
          end
        end
        default: begin
          if (bit_end) begin
            state_q <= IDLE;
          end
        end
      endcase
    end
  end

  // lsb first
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && start_i) begin
      shift_q <= data_i;
    end else if (state_q == DATA && bit_end) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  // bus side must hold off while a frame is out
  a_no_start_busy: assert property (@(posedge clk_i) disable iff (rst_i)
    busy_o |-> !start_i);

endmodule

// File: test/mini_mcu_golden.txt
# master (0 host, 1 ext), op (R read, W write, U expected UART byte), address, byte enable,
# write data, expected read data (or the expected byte on U lines), all hex except master
0 W 00000010 f 11223344 00000000
0 W 00000410 f 55667788 00000000
0 R 00000010 f 00000000 11223344
0 R 00000410 f 00000000 55667788
0 W 00000010 3 0000beef 00000000
0 W 00000410 c cafe0000 00000000
0 R 00000010 f 00000000 1122beef
0 R 00000410 f 00000000 cafe7788
0 W 20000000 f 00000042 00000000
0 W 20001000 f ffffffff 00000000
0 R 20000000 f 00000000 00000042
0 W 20000010 f 00000055 00000000
0 R 20000014 f 00000000 00000001
0 W 20000010 f 000000a3 00000000
0 R 20000014 f 00000000 00000001
0 U 00000000 0 00000000 00000055
0 U 00000000 0 00000000 000000a3
0 R 20000014 f 00000000 00000000
0 R 20000010 f 00000000 00000000
1 W 00000020 f a5a5a5a5 00000000
1 W 00000420 f 0badf00d 00000000
1 R 00000020 f 00000000 a5a5a5a5
1 R 00000420 f 00000000 0badf00d
1 W 00000000 f 76543210 00000000
1 W 00000020 9 12345677 00000000
1 W 00000420 6 00abcd00 00000000
1 R 00000020 f 00000000 12a5a577
1 R 00000420 f 00000000 0babcd0d
1 R 00000800 f 00000000 badc0de0
1 W 00000800 f deadbeef 00000000
1 R 00000000 f 00000000 76543210
1 R 40000000 f 00000000 badc0de0

// File: test/tb_mini_mcu.sv
////////////////////////////////////////
// run from the project root, golden path is relative
// first BURST_TXNS lines of each master go out with no gaps
////////////////////////////////////////
`timescale 1ns/10ps

module tb_mini_mcu;
  import mini_mcu_pkg::*;

  localparam int          MAX_LINES    = 64;
  localparam int          BURST_TXNS   = 4;
  localparam int          GNT_TIMEOUT  = 200;
  localparam int          SYNC_TIMEOUT = 3000;
  localparam int          UART_TIMEOUT = 3000;
  localparam logic [31:0] LCG_SEED     = 32'h0e01_f9ef;
  localparam logic [31:0] EXIT_ADDR    = PERIPH_BASE | 32'(EXIT_OFFSET);

  logic        clk, rst;
  logic        req [2];
  logic        we [2];
  logic [31:0] addr [2];
  logic [3:0]  be [2];
  logic [31:0] wdata [2];
  logic        gnt [2];
  logic        rvalid [2];
  logic [31:0] rdata [2];
  logic        exit_valid, uart_tx;
  logic [31:0] exit_value;

  int          g_mst [MAX_LINES];
  logic [7:0]  g_op [MAX_LINES];
  logic [31:0] g_addr [MAX_LINES];
  logic [3:0]  g_be [MAX_LINES];
  logic [31:0] g_wdata [MAX_LINES];
  logic [31:0] g_exp [MAX_LINES];
  // running count of U lines, used as a sync target
  int          g_useq [MAX_LINES];
  int          n_lines, uart_done, errors, checks;
  logic [31:0] exit_exp;
  logic        exit_seen;
  logic [31:0] lcg_state [2];
  string       pfx [2];

  // what the master has on the bus now, and what answers next cycle
  logic        cur_rd [2];
  logic [31:0] cur_exp [2];
  logic        pend [2];
  logic        pend_rd [2];
  logic [31:0] pend_exp [2];
  logic        last_ext;

  mini_mcu u_dut (
    .clk_i        (clk),
    .rst_i        (rst),
    .host_req_i   (req[0]),
    .host_we_i    (we[0]),
    .host_addr_i  (addr[0]),
    .host_be_i    (be[0]),
    .host_wdata_i (wdata[0]),
    .host_gnt_o   (gnt[0]),
    .host_rvalid_o(rvalid[0]),
    .host_rdata_o (rdata[0]),
    .ext_req_i    (req[1]),
    .ext_we_i     (we[1]),
    .ext_addr_i   (addr[1]),
    .ext_be_i     (be[1]),
    .ext_wdata_i  (wdata[1]),
    .ext_gnt_o    (gnt[1]),
    .ext_rvalid_o (rvalid[1]),
    .ext_rdata_o  (rdata[1]),
    .exit_valid_o (exit_valid),
    .exit_value_o (exit_value),
    .uart_tx_o    (uart_tx)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    errors++;
  endtask

  task automatic load_golden();
    int          fd;
    int          code;
    int          n_u;
    int          mst;
    logic [7:0]  op;
    logic [31:0] a, wd, ex;
    logic [3:0]  b;
    string       line;
    n_u = 0;
    fd = $fopen("test/mini_mcu_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden file");
      errors++;
      return;
    end
    while (!$feof(fd) && n_lines < MAX_LINES) begin
      code = $fgets(line, fd);
      if (code > 0 && line[0] != "#") begin
        code = $sscanf(line, "%d %c %h %h %h %h", mst, op, a, b, wd, ex);
        if (code == 6) begin
          if (op == "U") begin
            n_u++;
          end
          if (op == "W" && a == EXIT_ADDR) begin
            exit_exp  = wd;
            exit_seen = 1'b1;
          end
          g_mst[n_lines]   = mst;
          g_op[n_lines]    = op;
          g_addr[n_lines]  = a;
          g_be[n_lines]    = b;
          g_wdata[n_lines] = wd;
          g_exp[n_lines]   = ex;
          g_useq[n_lines]  = n_u;
          n_lines++;
        end
      end
    end
    $fclose(fd);
    if (n_lines == 0) begin
      $display("golden file holds no transactions");
      errors++;
    end
  endtask

  task automatic issue_txn(input int m, input int i, input int gap);
    int waited;
    if (gap > 0) begin
      req[m] = 1'b0;
    end
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
    we[m]      = (g_op[i] == "W");
    addr[m]    = g_addr[i];
    be[m]      = g_be[i];
    wdata[m]   = g_wdata[i];
    cur_rd[m]  = (g_op[i] == "R");
    cur_exp[m] = g_exp[i];
    req[m]     = 1'b1;
    waited     = 0;
    @(negedge clk);
    while (!gnt[m] && waited < GNT_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!gnt[m]) begin
      $display("%s master got no grant for %h within %0d cycles", pfx[m], g_addr[i], waited);
      errors++;
    end
    @(posedge clk);
    #1;
  endtask

  // hold off until the UART monitor has seen this many frames
  task automatic wait_frames(input int m, input int target);
    int waited;
    req[m] = 1'b0;
    waited = 0;
    while (uart_done < target && waited < SYNC_TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (uart_done < target) begin
      $display("%s master timed out waiting for UART frame %0d", pfx[m], target);
      errors++;
    end
  endtask

  task automatic run_master(input int m);
    int k;
    int gap;
    k = 0;
    for (int i = 0; i < n_lines; i++) begin
      if (g_mst[i] == m && g_op[i] == "U") begin
        wait_frames(m, g_useq[i]);
      end else if (g_mst[i] == m) begin
        lcg_state[m] = lcg_next(lcg_state[m]);
        gap = (k < BURST_TXNS) ? 0 : int'(lcg_state[m][31:30]);
        issue_txn(m, i, gap);
        k++;
      end
    end
    req[m] = 1'b0;
  endtask

  // samples near bit centres, start seen in its first cycle
  task automatic watch_uart();
    int         waited;
    logic [7:0] got;
    for (int i = 0; i < n_lines; i++) begin
      if (g_op[i] == "U") begin
        waited = 0;
        @(negedge clk);
        while (uart_tx !== 1'b0 && waited < UART_TIMEOUT) begin
          @(negedge clk);
          waited++;
        end
        if (uart_tx !== 1'b0) begin
          $display("no UART start bit for byte %h", g_exp[i][7:0]);
          errors++;
          return;
        end
        repeat (2) @(negedge clk);
        checks++;
        if (uart_tx !== 1'b0) begin
          report_mismatch("uart_tx_o start bit", 32'h0, 32'(uart_tx));
        end
        for (int b = 0; b < 8; b++) begin
          repeat (UART_CLKS_PER_BIT) @(negedge clk);
          got[b] = uart_tx;
        end
        repeat (UART_CLKS_PER_BIT) @(negedge clk);
        checks += 2;
        if (uart_tx !== 1'b1) begin
          report_mismatch("uart_tx_o stop bit", 32'h1, 32'(uart_tx));
        end
        if (got !== g_exp[i][7:0]) begin
          report_mismatch("uart_tx_o byte", 32'(g_exp[i][7:0]), 32'(got));
        end
        // last cycle of the stop bit
        @(negedge clk);
        uart_done++;
      end
    end
  endtask

  // rvalid one cycle after gnt, read data, round-robin rule
  always @(negedge clk) begin
    int win;
    if (rst) begin
      last_ext = 1'b1;
      pend[0]  = 1'b0;
      pend[1]  = 1'b0;
    end else begin
      for (int m = 0; m < 2; m++) begin
        checks++;
        if (rvalid[m] !== pend[m]) begin
          report_mismatch({pfx[m], "rvalid_o"}, 32'(pend[m]), 32'(rvalid[m]));
        end else if (pend[m] && pend_rd[m] && rdata[m] !== pend_exp[m]) begin
          report_mismatch({pfx[m], "rdata_o"}, pend_exp[m], rdata[m]);
        end
      end
      win = last_ext ? 0 : 1;
      if (gnt[0] && gnt[1]) begin
        $display("Error at %0t: both masters granted in one cycle", $time);
        errors++;
      end else if (req[0] && req[1] && gnt[1 - win]) begin
        report_mismatch("granted master", 32'(win), 32'(1 - win));
      end
      if (gnt[0]) begin
        last_ext = 1'b0;
      end
      if (gnt[1]) begin
        last_ext = 1'b1;
      end
      for (int m = 0; m < 2; m++) begin
        pend[m]     = gnt[m];
        pend_rd[m]  = cur_rd[m];
        pend_exp[m] = cur_exp[m];
      end
    end
  end

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rst       = 1'b1;
    n_lines   = 0;
    uart_done = 0;
    errors    = 0;
    checks    = 0;
    exit_exp  = '0;
    exit_seen = 1'b0;
    pfx[0]    = "host_";
    pfx[1]    = "ext_";
    for (int m = 0; m < 2; m++) begin
      req[m]       = 1'b0;
      we[m]        = 1'b0;
      addr[m]      = '0;
      be[m]        = '0;
      wdata[m]     = '0;
      cur_rd[m]    = 1'b0;
      cur_exp[m]   = '0;
      lcg_state[m] = LCG_SEED ^ 32'(m);
    end
    load_golden();
    repeat (4) @(posedge clk);
    @(negedge clk);
    checks += 2;
    if (uart_tx !== 1'b1) begin
      report_mismatch("uart_tx_o", 32'h1, 32'(uart_tx));
    end
    if (exit_valid !== 1'b0) begin
      report_mismatch("exit_valid_o", 32'h0, 32'(exit_valid));
    end
    @(posedge clk);
    #1;
    rst = 1'b0;
    fork
      run_master(0);
      run_master(1);
      watch_uart();
    join
    repeat (3) @(negedge clk);
    if (exit_seen) begin
      checks += 2;
      if (exit_valid !== 1'b1) begin
        report_mismatch("exit_valid_o", 32'h1, 32'(exit_valid));
      end
      if (exit_value !== exit_exp) begin
        report_mismatch("exit_value_o", exit_exp, exit_value);
      end
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
